/* common/mem_system_pkg.sv */
// memory system package
// address split, cache geometry and main memory timing shared by all blocks

`default_nettype none

package mem_system_pkg;

    // datapath widths
    localparam int word_w = 16;
    localparam int addr_w = 16;

    // cache geometry
    localparam int tag_w           = 5;
    localparam int index_w         = 8;
    localparam int words_per_block = 4;
    localparam int word_sel_w      = $clog2(words_per_block);
    localparam int num_sets        = 2 ** index_w;

    // field positions in a byte address, bit 0 is the byte bit
    localparam int index_lo = word_sel_w + 1;
    localparam int tag_lo   = index_lo + index_w;

    // main memory, one bank per word of a block
    localparam int mem_words        = 2 ** (addr_w - 1);
    localparam int mem_latency      = 2;
    localparam int bank_busy_cycles = 4;

endpackage

`default_nettype wire

/* cache/cache_way.sv */
// cache way
// one way of the two-way cache: tag, valid, dirty and data arrays
// lookup is combinational, updates land on the clock edge

`timescale 1ns/1ps
`default_nettype none

module cache_way
    import mem_system_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   enable,
    input  wire                   comp,
    input  wire                   write,
    input  wire [tag_w-1:0]       tag_in,
    input  wire [index_w-1:0]     index,
    input  wire [word_sel_w-1:0]  word_sel,
    input  wire [word_w-1:0]      data_in,
    input  wire                   valid_in,
    output logic                  hit,
    output logic                  valid,
    output logic                  dirty,
    output logic [tag_w-1:0]      tag_out,
    output logic [word_w-1:0]     data_out
);

    logic [num_sets-1:0] valid_mem;
    logic [num_sets-1:0] dirty_mem;
    logic [tag_w-1:0]    tag_mem  [num_sets];
    logic [word_w-1:0]   data_mem [num_sets * words_per_block];

    logic update;

    assign update = enable && write;

    // lookup of the addressed set
    assign valid    = valid_mem[index];
    assign dirty    = dirty_mem[index];
    assign tag_out  = tag_mem[index];
    assign data_out = data_mem[{index, word_sel}];
    assign hit      = enable && comp && valid && (tag_out == tag_in);

    // valid bits, only an access-mode write (a fill) changes them
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_mem <= '0;
        end else if (update && !comp) begin
            valid_mem[index] <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            data_mem[{index, word_sel}] <= data_in;
            if (comp) begin
                // cpu write hit
                dirty_mem[index] <= 1'b1;
            end else begin
                // fill word, line comes in clean under the new tag
                dirty_mem[index] <= 1'b0;
                tag_mem[index]   <= tag_in;
            end
        end
    end

    // the top only lets the enabled way see a write
    a_write_needs_enable: assert property (
        @(posedge clk) disable iff (reset) write |-> enable
    );

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
// cache controller
// latches and checks cpu requests, runs the hit/miss FSM with write-back and
// fill sequencing against the banked memory, and keeps the victim bit

`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import mem_system_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   rd,
    input  wire                   wr,
    input  wire [addr_w-1:0]      addr,
    input  wire [word_w-1:0]      data_in,
    input  wire                   way_hit,
    input  wire                   way_valid,
    input  wire                   way_dirty,
    input  wire [tag_w-1:0]       way_tag,
    input  wire                   mem_stall,
    input  wire [word_w-1:0]      mem_data,
    output logic [addr_w-1:0]     req_addr,
    output logic                  way_sel,
    output logic [1:0]            way_en,
    output logic                  comp,
    output logic                  write,
    output logic                  valid_in,
    output logic [word_sel_w-1:0] word_sel,
    output logic [word_w-1:0]     fill_data,
    output logic                  use_mem_data,
    output logic [addr_w-1:0]     mem_addr,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic                  done,
    output logic                  stall,
    output logic                  cache_hit,
    output logic                  err
);

    typedef enum logic [2:0] {
        st_idle, st_compare, st_probe, st_wb, st_fill, st_access
    } state_t;

    state_t                state;
    logic [addr_w-1:0]     addr_q;
    logic [word_w-1:0]     data_q;
    logic                  wr_q;
    logic                  sel_q;
    logic                  victim;
    logic                  dirty0_q;
    logic                  err_q;
    logic [word_sel_w:0]   cnt;
    logic [mem_latency-1:0] pend_v;
    logic [word_sel_w-1:0] pend_w [mem_latency];

    logic                  bad_req;
    logic                  accept;
    logic                  rd_go;
    logic                  fill_wr;
    logic                  fill_last;
    logic [tag_w-1:0]      req_tag;
    logic [index_w-1:0]    req_index;
    logic [1:0]            sel_onehot;

    assign bad_req    = (rd && wr) || addr[0];
    assign accept     = (state == st_idle) && (rd || wr) && !bad_req;
    assign req_tag    = addr_q[addr_w-1:tag_lo];
    assign req_index  = addr_q[tag_lo-1:index_lo];
    assign sel_onehot = sel_q ? 2'b10 : 2'b01;

    // fill reads go out in word order, each lands mem_latency cycles later
    assign rd_go     = (state == st_fill) && !cnt[word_sel_w] && !mem_stall;
    assign fill_wr   = (state == st_fill) && pend_v[mem_latency-1];
    assign fill_last = fill_wr && (pend_w[mem_latency-1] == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_idle;
            victim <= 1'b0;
            sel_q  <= 1'b0;
            err_q  <= 1'b0;
            cnt    <= '0;
            pend_v <= '0;
        end else begin
            err_q     <= (state == st_idle) && (rd || wr) && bad_req;
            pend_v[0] <= rd_go;
            for (int k = 1; k < mem_latency; k++) begin
                pend_v[k] <= pend_v[k-1];
            end
            case (state)
                st_idle: begin
                    if (accept) begin
                        victim <= !victim;
                        sel_q  <= 1'b0;
                        cnt    <= '0;
                        state  <= st_compare;
                    end
                end
                st_compare: begin
                    // way 0 is looked at on a miss
                    if (way_hit) begin
                        state <= st_idle;
                    end else if (!way_valid) begin
                        state <= st_fill;
                    end else begin
                        sel_q <= 1'b1;
                        state <= st_probe;
                    end
                end
                st_probe: begin
                    if (!way_valid) begin
                        state <= st_fill;
                    end else begin
                        // both ways full
                        sel_q <= victim;
                        state <= (victim ? way_dirty : dirty0_q) ? st_wb : st_fill;
                    end
                end
                st_wb: begin
                    if (!mem_stall) begin
                        if (cnt[word_sel_w-1:0] == '1) begin
                            cnt   <= '0;
                            state <= st_fill;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                st_fill: begin
                    if (rd_go) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (fill_last) begin
                        state <= st_access;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // request payload and word tags of outstanding fill reads
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;
            data_q <= data_in;
            wr_q   <= wr;
        end
        if (state == st_compare) begin
            dirty0_q <= way_dirty;
        end
        pend_w[0] <= cnt[word_sel_w-1:0];
        for (int k = 1; k < mem_latency; k++) begin
            pend_w[k] <= pend_w[k-1];
        end
    end

    always_comb begin
        way_en       = 2'b00;
        comp         = 1'b0;
        write        = 1'b0;
        valid_in     = 1'b0;
        word_sel     = cnt[word_sel_w-1:0];
        use_mem_data = 1'b0;
        mem_rd       = 1'b0;
        mem_wr       = 1'b0;
        mem_addr     = {req_tag, req_index, cnt[word_sel_w-1:0], 1'b0};
        done         = 1'b0;
        cache_hit    = 1'b0;
        case (state)
            st_compare: begin
                way_en    = 2'b11;
                comp      = 1'b1;
                write     = wr_q && way_hit;
                done      = way_hit;
                cache_hit = way_hit;
            end
            st_wb: begin
                // victim word goes back under its own tag
                way_en   = sel_onehot;
                mem_wr   = 1'b1;
                mem_addr = {way_tag, req_index, cnt[word_sel_w-1:0], 1'b0};
            end
            st_fill: begin
                way_en       = sel_onehot;
                mem_rd       = !cnt[word_sel_w];
                write        = fill_wr;
                valid_in     = 1'b1;
                use_mem_data = 1'b1;
                word_sel     = pend_w[mem_latency-1];
            end
            st_access: begin
                way_en = 2'b11;
                comp   = 1'b1;
                write  = wr_q && way_hit;
                done   = 1'b1;
            end
            default: begin
                way_en = 2'b00;
            end
        endcase
    end

    assign req_addr  = addr_q;
    assign way_sel   = sel_q;
    assign fill_data = data_q;
    assign stall     = (state != st_idle);
    assign err       = err_q;

    a_mem_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset) !(mem_rd && mem_wr)
    );
    a_no_done_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !done
    );
    a_done_err_excl: assert property (
        @(posedge clk) disable iff (reset) !(done && err)
    );

endmodule

`default_nettype wire

/* verilog/banked_mem.sv */
// banked main memory
// four interleaved banks selected by word address bits, fixed read latency
// and a busy window per bank after each access

`timescale 1ns/1ps
`default_nettype none

module banked_mem
    import mem_system_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire [addr_w-1:0]   addr,
    input  wire [word_w-1:0]   data_in,
    input  wire                rd,
    input  wire                wr,
    output logic [word_w-1:0]  data_out,
    output logic               stall
);

    localparam int busy_w = $clog2(bank_busy_cycles + 1);

    logic [word_w-1:0] storage [mem_words] = '{default: '0};
    logic [busy_w-1:0] busy    [words_per_block];
    logic [word_w-1:0] rd_pipe [mem_latency];

    logic [addr_w-2:0]     word_idx;
    logic [word_sel_w-1:0] bank;
    logic                  accept;

    assign word_idx = addr[addr_w-1:1];
    assign bank     = addr[word_sel_w:1];
    assign stall    = (busy[bank] != '0);
    assign accept   = (rd || wr) && !stall;

    // per-bank busy counters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < words_per_block; b++) begin
                busy[b] <= '0;
            end
        end else begin
            for (int b = 0; b < words_per_block; b++) begin
                if (accept && (bank == word_sel_w'(b))) begin
                    busy[b] <= busy_w'(bank_busy_cycles);
                end else if (busy[b] != '0) begin
                    busy[b] <= busy[b] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && wr) begin
            storage[word_idx] <= data_in;
        end
    end

    // read delay line
    always_ff @(posedge clk) begin
        rd_pipe[0] <= storage[word_idx];
        for (int k = 1; k < mem_latency; k++) begin
            rd_pipe[k] <= rd_pipe[k-1];
        end
    end

    assign data_out = rd_pipe[mem_latency-1];

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (reset) !(rd && wr)
    );

endmodule

`default_nettype wire

/* verilog/mem_system.sv */
// memory system top
// two-way write-back cache with its controller in front of the banked
// main memory; selects the way and muxes addresses and write data

`timescale 1ns/1ps
`default_nettype none

module mem_system
    import mem_system_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire [addr_w-1:0]   addr,
    input  wire [word_w-1:0]   data_in,
    input  wire                rd,
    input  wire                wr,
    output logic [word_w-1:0]  data_out,
    output logic               done,
    output logic               stall,
    output logic               cache_hit,
    output logic               err
);

    logic [addr_w-1:0]     req_addr;
    logic [addr_w-1:0]     mem_addr;
    logic [word_w-1:0]     fill_data;
    logic [word_w-1:0]     mem_out;
    logic [word_w-1:0]     way_wdata;
    logic [word_sel_w-1:0] ctrl_word_sel;
    logic [word_sel_w-1:0] way_word_sel;
    logic [1:0]            way_en;
    logic                  way_sel;
    logic                  comp;
    logic                  write;
    logic                  valid_in;
    logic                  use_mem_data;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  mem_stall;
    logic                  sel;
    logic [1:0]            way_write;
    logic [1:0]            hit;
    logic [1:0]            valid;
    logic [1:0]            dirty;
    logic [tag_w-1:0]      tag0;
    logic [tag_w-1:0]      tag1;
    logic [word_w-1:0]     data0;
    logic [word_w-1:0]     data1;

    // hitting way first, otherwise the way the controller is working on
    assign sel = hit[0] ? 1'b0 : (hit[1] ? 1'b1 : way_sel);

    // a compare write only goes to the way that hit
    assign way_write[0] = write && way_en[0] && (!comp || hit[0]);
    assign way_write[1] = write && way_en[1] && (!comp || hit[1]);

    assign way_word_sel = comp ? req_addr[index_lo-1:1] : ctrl_word_sel;
    assign way_wdata    = use_mem_data ? mem_out : fill_data;
    assign data_out     = sel ? data1 : data0;

    cache_way u_way0 (
        .clk(clk), .reset(reset), .enable(way_en[0]), .comp(comp), .write(way_write[0]),
        .tag_in(req_addr[addr_w-1:tag_lo]), .index(req_addr[tag_lo-1:index_lo]),
        .word_sel(way_word_sel), .data_in(way_wdata), .valid_in(valid_in),
        .hit(hit[0]), .valid(valid[0]), .dirty(dirty[0]), .tag_out(tag0), .data_out(data0)
    );

    cache_way u_way1 (
        .clk(clk), .reset(reset), .enable(way_en[1]), .comp(comp), .write(way_write[1]),
        .tag_in(req_addr[addr_w-1:tag_lo]), .index(req_addr[tag_lo-1:index_lo]),
        .word_sel(way_word_sel), .data_in(way_wdata), .valid_in(valid_in),
        .hit(hit[1]), .valid(valid[1]), .dirty(dirty[1]), .tag_out(tag1), .data_out(data1)
    );

    cache_ctrl u_ctrl (
        .clk(clk), .reset(reset), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
        .way_hit(hit[sel]), .way_valid(valid[sel]), .way_dirty(dirty[sel]),
        .way_tag(sel ? tag1 : tag0), .mem_stall(mem_stall), .mem_data(mem_out),
        .req_addr(req_addr), .way_sel(way_sel), .way_en(way_en), .comp(comp),
        .write(write), .valid_in(valid_in), .word_sel(ctrl_word_sel),
        .fill_data(fill_data), .use_mem_data(use_mem_data), .mem_addr(mem_addr),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .done(done), .stall(stall),
        .cache_hit(cache_hit), .err(err)
    );

    // write-back data comes straight from the selected way
    banked_mem u_mem (
        .clk(clk), .reset(reset), .addr(mem_addr), .data_in(data_out),
        .rd(mem_rd), .wr(mem_wr), .data_out(mem_out), .stall(mem_stall)
    );

endmodule

`default_nettype wire

/* verif/mem_system_tb.sv */
// memory system testbench
// directed and LFSR driven requests checked against a model of memory
// contents and of the cache tags, with a watchdog on the whole run

`timescale 1ns/1ps
`default_nettype none

module mem_system_tb
    import mem_system_pkg::*;
;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 10;
    localparam int miss_bound      = 40;
    localparam int n_random        = 48;
    localparam int total_requests  = 1 + 2 + 6 + n_random + 4 + 4;
    localparam int watchdog_cycles = reset_cycles + total_requests * miss_bound;

    logic              clk;
    logic              reset;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] data_in;
    logic              rd;
    logic              wr;
    logic [word_w-1:0] data_out;
    logic              done;
    logic              stall;
    logic              cache_hit;
    logic              err;

    // reference model
    logic [word_w-1:0] mem_model   [mem_words];
    logic [tag_w-1:0]  tag_model   [num_sets][2];
    logic              valid_model [num_sets][2];
    logic              victim_model;
    logic [31:0]       lfsr;
    int                errors = 0;
    int                checks = 0;

    mem_system u_dut (
        .clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
        .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // taps 32, 22, 2, 1, one step per bit
    function automatic logic [word_w-1:0] lfsr_bits(input int n);
        logic [word_w-1:0] r;
        logic              fb;
        int                i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[word_w-2:0], fb};
        end
        return r;
    endfunction

    function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] t,
            input logic [index_w-1:0] idx, input logic [word_sel_w-1:0] w);
        return {t, idx, w, 1'b0};
    endfunction

    // predicts cache_hit and allocates on a miss, empty way first
    function automatic logic model_access(input logic [addr_w-1:0] a);
        logic [tag_w-1:0]   t;
        logic [index_w-1:0] idx;
        logic               hit;
        int                 w;
        int                 way;
        t            = a[addr_w-1:tag_lo];
        idx          = a[tag_lo-1:index_lo];
        victim_model = !victim_model;
        hit          = 1'b0;
        for (w = 0; w < 2; w++) begin
            if (valid_model[idx][w] && (tag_model[idx][w] == t)) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            if (!valid_model[idx][0]) begin
                way = 0;
            end else if (!valid_model[idx][1]) begin
                way = 1;
            end else begin
                way = victim_model ? 1 : 0;
            end
            valid_model[idx][way] = 1'b1;
            tag_model[idx][way]   = t;
        end
        return hit;
    endfunction

    task automatic check_word(input string name, input logic [word_w-1:0] got,
            input logic [word_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // strobes drop at the first falling edge, outputs sampled there
    task automatic wait_response(output int cycles, output logic saw_done,
            output logic saw_err);
        cycles   = 0;
        saw_done = 1'b0;
        saw_err  = 1'b0;
        while (!saw_done && !saw_err && (cycles < miss_bound)) begin
            @(negedge clk);
            rd       = 1'b0;
            wr       = 1'b0;
            cycles++;
            saw_done = done;
            saw_err  = err;
        end
    endtask

    task automatic access_and_check(input logic is_wr, input logic [addr_w-1:0] a,
            input logic [word_w-1:0] d, input logic exp_hit, input logic [word_w-1:0] exp_data);
        int   cycles;
        logic saw_done;
        logic saw_err;
        @(negedge clk);
        addr    = a;
        data_in = d;
        rd      = !is_wr;
        wr      = is_wr;
        wait_response(cycles, saw_done, saw_err);
        if (!saw_done || saw_err) begin
            $display("request at %h (wr %b) got no done, err %b, after %0d cycles",
                a, is_wr, saw_err, cycles);
            errors++;
        end else begin
            check_flag("cache_hit", cache_hit, exp_hit);
            check_flag("stall", stall, 1'b1);
            if (!is_wr) begin
                check_word("data_out", data_out, exp_data);
            end
            if (exp_hit && (cycles != 1)) begin
                $display("hit at %h took %0d cycles instead of one", a, cycles);
                errors++;
            end
        end
    endtask

    task automatic do_read(input logic [addr_w-1:0] a);
        logic exp_hit;
        exp_hit = model_access(a);
        access_and_check(1'b0, a, '0, exp_hit, mem_model[a[addr_w-1:1]]);
    endtask

    task automatic do_write(input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
        logic exp_hit;
        exp_hit = model_access(a);
        mem_model[a[addr_w-1:1]] = d;
        access_and_check(1'b1, a, d, exp_hit, d);
    endtask

    task automatic reject_request(input logic r, input logic w, input logic [addr_w-1:0] a,
            input logic [word_w-1:0] d);
        int   cycles;
        logic saw_done;
        logic saw_err;
        @(negedge clk);
        addr    = a;
        data_in = d;
        rd      = r;
        wr      = w;
        wait_response(cycles, saw_done, saw_err);
        if (!saw_err || saw_done || (cycles != 1)) begin
            $display("request at %h rd %b wr %b was not rejected in the next cycle", a, r, w);
            errors++;
        end
        @(negedge clk);
        check_flag("err", err, 1'b0);
        check_flag("done", done, 1'b0);
    endtask

    task automatic first_read_after_reset();
        check_flag("done", done, 1'b0);
        check_flag("stall", stall, 1'b0);
        check_flag("err", err, 1'b0);
        check_flag("cache_hit", cache_hit, 1'b0);
        do_read(16'h5a5a);
    endtask

    task automatic write_read_hit();
        do_write(make_addr(5'h04, 8'h10, 2'd2), 16'hbeef);
        do_read(make_addr(5'h04, 8'h10, 2'd2));
    endtask

    // third tag at one index pushes a dirty line out
    task automatic dirty_eviction();
        int t;
        for (t = 1; t <= 3; t++) begin
            do_write(make_addr(tag_w'(t), 8'h3c, word_sel_w'(t)), 16'h3c00 + word_w'(t));
        end
        for (t = 1; t <= 3; t++) begin
            do_read(make_addr(tag_w'(t), 8'h3c, word_sel_w'(t)));
        end
    endtask

    task automatic random_mix();
        logic [addr_w-1:0] a;
        logic [word_w-1:0] d;
        logic              is_wr;
        int                n;
        for (n = 0; n < n_random; n++) begin
            a     = make_addr(tag_w'(lfsr_bits(2)), 8'h80 + index_w'(lfsr_bits(2)),
                              word_sel_w'(lfsr_bits(2)));
            is_wr = lfsr_bits(1) != '0;
            d     = lfsr_bits(16);
            if (is_wr) begin
                do_write(a, d);
            end else begin
                do_read(a);
            end
        end
    endtask

    task automatic rejected_requests();
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] b;
        a = make_addr(5'h02, 8'h81, 2'd2);
        b = make_addr(5'h03, 8'h81, 2'd0);
        reject_request(1'b1, 1'b1, a, 16'h1bad);
        reject_request(1'b0, 1'b1, b | 16'h0001, 16'h2bad);
        do_read(a);
        do_read(b);
    endtask

    // a miss keeps stall high while a stray write is offered
    task automatic strobes_during_stall();
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] b;
        logic              exp_hit;
        int                cycles;
        logic              saw_done;
        logic              saw_err;
        a       = make_addr(5'h11, 8'hf0, 2'd1);
        b       = make_addr(5'h01, 8'h3c, 2'd1);
        exp_hit = model_access(a);
        mem_model[a[addr_w-1:1]] = 16'h600d;
        @(negedge clk);
        addr    = a;
        data_in = 16'h600d;
        wr      = 1'b1;
        @(negedge clk);
        wr = 1'b0;
        check_flag("stall", stall, 1'b1);
        check_flag("done", done, 1'b0);
        addr    = b;
        data_in = 16'hdead;
        wr      = 1'b1;
        wait_response(cycles, saw_done, saw_err);
        if (!saw_done || saw_err) begin
            $display("write miss at %h got no done while a stray strobe was offered", a);
            errors++;
        end else begin
            check_flag("cache_hit", cache_hit, exp_hit);
        end
        do_read(b);
        do_read(a);
    endtask

    initial begin
        int i;
        reset   = 1'b1;
        rd      = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        data_in = '0;
        lfsr    = 32'h9dcf89a0;
        victim_model = 1'b0;
        for (i = 0; i < mem_words; i++) begin
            mem_model[i] = '0;
        end
        for (i = 0; i < num_sets; i++) begin
            valid_model[i][0] = 1'b0;
            valid_model[i][1] = 1'b0;
        end
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        first_read_after_reset();
        write_read_hit();
        dirty_eviction();
        random_mix();
        rejected_requests();
        strobes_during_stall();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
common/mem_system_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
verilog/banked_mem.sv
verilog/mem_system.sv
verif/mem_system_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the memory system testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module mem_system_tb \
    -o mem_system_sim \
    && ./obj_dir/mem_system_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
